// ==== Bender.yml ====
package:
  name: tiny_pipe

sources:
  # design, package first
  - tiny_pipe_pkg.sv
  - tiny_pipe_regfile.sv
  - tiny_pipe_decode.sv
  - tiny_pipe_id_ex.sv
  - tiny_pipe_execute.sv
  - tiny_pipe_result.sv
  - tiny_pipe_top.sv

  # testbench
  - target: test
    files:
      - tb_tiny_pipe.sv

// ==== tb_tiny_pipe.sv ====
// tiny_pipe testbench
// table of RV32I words checked against a non-pipelined register model,
// random back-pressure on the result port and one flush of a stalled word
`timescale 1ns/1ps
`default_nettype none

module tb_tiny_pipe;

    localparam int MAX_ENTRIES = 64;
    localparam int TIMEOUT     = 200;  // cycles per wait loop

    logic        clk_i;
    logic        rst_n_i;
    logic        flush_i;
    logic        in_valid_i;
    logic [31:0] in_inst_i;
    logic [31:0] in_addr_i;
    logic        in_ready_o;
    logic        res_valid_o;
    logic [31:0] res_addr_o;
    logic [4:0]  res_rd_o;
    logic        res_we_o;
    logic [31:0] res_data_o;
    logic        res_ready_i;

    logic [31:0] tbl_inst   [MAX_ENTRIES];
    logic        tbl_flush  [MAX_ENTRIES];  // word is flushed from id_ex
    logic        exp_we     [MAX_ENTRIES];
    logic [31:0] exp_data   [MAX_ENTRIES];
    logic [31:0] model_regs [32];
    int          n_entries;
    int          sent_count;     // accepted words that must retire
    int          retired_count;
    logic [15:0] lfsr_state;
    logic        hold_ready;     // parks res_ready_i low

    tiny_pipe_top #(.NUM_REGS(32)) i_dut (.*);

    always #10 clk_i = ~clk_i;

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] word_addr(input int idx);
        return 32'h0000_1000 + idx * 4;
    endfunction

    // right-shifting galois form, taps 16,14,13,11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) return (s >> 1) ^ 16'hB400;
        return s >> 1;
    endfunction

    task automatic stop_run();
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic value_error(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
        $display("** Error at %0t ns: %s expected %h, got %h", $time, field, expected, actual);
        stop_run();
    endtask

    task automatic timeout_abort(input string what);
        $display("timeout at %0t ns while waiting for %s", $time, what);
        stop_run();
    endtask

    // executes one word on the model registers and records what must retire
    task automatic add_entry(input logic [31:0] w, input logic flush_after);
        logic [31:0]        a;
        logic [31:0]        b;
        logic signed [31:0] sa;
        logic [31:0]        val;
        logic [2:0]         f3;
        logic               is_op;
        logic               ok;
        a     = model_regs[w[19:15]];
        b     = model_regs[w[24:20]];
        sa    = a;
        f3    = w[14:12];
        is_op = (w[6:0] == 7'b0110011);
        ok    = 1'b1;
        val   = '0;
        if (w[6:0] == 7'b0110111) begin
            val = {w[31:12], 12'h000};
        end else if (is_op || w[6:0] == 7'b0010011) begin
            if (!is_op) b = {{20{w[31]}}, w[31:20]};
            if (is_op || f3 == 3'd1 || f3 == 3'd5) begin
                ok = (w[31:25] == 7'h00) ||
                     (w[31:25] == 7'h20 && (f3 == 3'd5 || (f3 == 3'd0 && is_op)));
            end
            case (f3)
                3'd0: val = (is_op && w[30]) ? a - b : a + b;
                3'd1: val = a << b[4:0];
                3'd2: val = {31'b0, $signed(a) < $signed(b)};
                3'd3: val = {31'b0, a < b};
                3'd4: val = a ^ b;
                3'd5: begin
                    if (w[30]) val = sa >>> b[4:0];
                    else val = a >> b[4:0];
                end
                3'd6: val = a | b;
                default: val = a & b;
            endcase
        end else begin
            ok = 1'b0;  // loads, branches and the rest
        end
        tbl_inst[n_entries]  = w;
        tbl_flush[n_entries] = flush_after;
        exp_we[n_entries]    = ok && w[11:7] != 5'd0;
        exp_data[n_entries]  = val;
        if (!flush_after && exp_we[n_entries]) model_regs[w[11:7]] = val;
        n_entries++;
    endtask

    task automatic build_table();
        add_entry(lui_word(20'hFFFFF, 5'd1), 1'b0);
        add_entry(i_word(12'h7FF, 5'd1, 3'd0, 5'd1), 1'b0);      // back to back on x1
        add_entry(i_word(12'd100, 5'd0, 3'd0, 5'd2), 1'b0);
        add_entry(i_word(12'hFF9, 5'd0, 3'd0, 5'd3), 1'b0);      // -7
        add_entry(r_word(7'h00, 5'd3, 5'd2, 3'd0, 5'd4), 1'b0);  // add
        add_entry(r_word(7'h20, 5'd2, 5'd3, 3'd0, 5'd5), 1'b0);  // sub
        add_entry(r_word(7'h00, 5'd3, 5'd1, 3'd7, 5'd6), 1'b0);  // and
        add_entry(r_word(7'h00, 5'd3, 5'd2, 3'd6, 5'd7), 1'b0);  // or
        add_entry(r_word(7'h00, 5'd2, 5'd1, 3'd4, 5'd8), 1'b0);  // xor
        add_entry(r_word(7'h00, 5'd2, 5'd3, 3'd2, 5'd9), 1'b0);  // slt
        add_entry(r_word(7'h00, 5'd2, 5'd3, 3'd3, 5'd10), 1'b0); // sltu
        add_entry(r_word(7'h00, 5'd2, 5'd2, 3'd1, 5'd11), 1'b0); // sll
        add_entry(r_word(7'h00, 5'd2, 5'd3, 3'd5, 5'd12), 1'b0); // srl
        add_entry(r_word(7'h20, 5'd2, 5'd3, 3'd5, 5'd13), 1'b0); // sra of a negative
        add_entry(i_word(12'h0F0, 5'd1, 3'd7, 5'd14), 1'b0);     // andi
        add_entry(i_word(12'h100, 5'd3, 3'd6, 5'd15), 1'b0);     // ori
        add_entry(i_word(12'hFFF, 5'd2, 3'd4, 5'd16), 1'b0);     // xori
        add_entry(i_word(12'hFFA, 5'd3, 3'd2, 5'd17), 1'b0);     // slti
        add_entry(i_word(12'hFFF, 5'd3, 3'd3, 5'd18), 1'b0);     // sltiu
        add_entry(i_word({7'h00, 5'd3}, 5'd2, 3'd1, 5'd19), 1'b0);
        add_entry(i_word({7'h00, 5'd28}, 5'd3, 3'd5, 5'd20), 1'b0);
        add_entry(i_word({7'h20, 5'd8}, 5'd1, 3'd5, 5'd21), 1'b0);  // srai
        add_entry(r_word(7'h00, 5'd21, 5'd19, 3'd0, 5'd19), 1'b0);
        add_entry(i_word(12'd55, 5'd0, 3'd0, 5'd0), 1'b0);       // write to x0
        add_entry(r_word(7'h00, 5'd0, 5'd0, 3'd0, 5'd22), 1'b0);
        add_entry(32'h0000_2083, 1'b0);                          // lw x1
        add_entry(32'h0020_8063, 1'b0);                          // beq
        add_entry(r_word(7'h20, 5'd3, 5'd1, 3'd7, 5'd23), 1'b0); // bad funct7
        add_entry(r_word(7'h00, 5'd1, 5'd23, 3'd0, 5'd24), 1'b0);
        add_entry(i_word({7'h20, 5'd1}, 5'd1, 3'd1, 5'd25), 1'b0);
        add_entry(i_word(12'd11, 5'd0, 3'd0, 5'd26), 1'b0);      // parked in result slot
        add_entry(i_word(12'd999, 5'd0, 3'd0, 5'd2), 1'b1);      // flushed from id_ex
        add_entry(r_word(7'h00, 5'd26, 5'd2, 3'd0, 5'd27), 1'b0);
        add_entry(r_word(7'h20, 5'd1, 5'd27, 3'd0, 5'd28), 1'b0);
        add_entry(r_word(7'h00, 5'd28, 5'd2, 3'd1, 5'd29), 1'b0);
        add_entry(r_word(7'h00, 5'd4, 5'd5, 3'd2, 5'd30), 1'b0);
        add_entry(r_word(7'h00, 5'd30, 5'd29, 3'd4, 5'd31), 1'b0);
    endtask

    // called at 2 ns after a rising edge, returns at the same phase
    task automatic send_word(input int idx);
        int   cycles;
        logic taken;
        cycles     = 0;
        taken      = 1'b0;
        in_valid_i = 1'b1;
        in_inst_i  = tbl_inst[idx];
        in_addr_i  = word_addr(idx);
        while (!taken) begin
            @(negedge clk_i);
            taken = in_ready_o;  // accepted on the coming edge
            @(posedge clk_i);
            #2;
            cycles++;
            if (!taken && cycles > TIMEOUT) timeout_abort("in_ready_o to accept a word");
        end
        in_valid_i = 1'b0;
        if (!tbl_flush[idx]) sent_count++;
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        @(negedge clk_i);
        while (retired_count != sent_count) begin
            cycles++;
            if (cycles > TIMEOUT) timeout_abort("the pipeline to drain");
            @(negedge clk_i);
        end
    endtask

    task automatic flush_held(input int idx);
        int cycles;
        cycles = 0;
        @(negedge clk_i);
        while (in_ready_o) begin
            cycles++;
            if (cycles > TIMEOUT) timeout_abort("in_ready_o to drop before the flush");
            @(negedge clk_i);
        end
        assert (res_valid_o) else value_error("res_valid_o before flush", 32'd1, 32'd0);
        assert (res_addr_o == word_addr(idx - 1))
            else value_error("res_addr_o before flush", word_addr(idx - 1), res_addr_o);
        @(posedge clk_i);
        #2;
        flush_i = 1'b1;
        @(posedge clk_i);
        #2;
        flush_i = 1'b0;
        @(negedge clk_i);
        // result slot still stalled, so only an emptied id_ex raises ready
        assert (in_ready_o) else value_error("in_ready_o after flush", 32'd1, 32'd0);
        hold_ready = 1'b0;
        @(posedge clk_i);
        #2;
    endtask

    task automatic drive_inputs();
        int i;
        for (i = 0; i < n_entries; i++) begin
            if (i + 1 < n_entries && tbl_flush[i + 1]) begin
                wait_drained();
                hold_ready = 1'b1;  // next word stays in the result slot
                @(posedge clk_i);
                #2;
            end
            send_word(i);
            if (tbl_flush[i]) flush_held(i);
        end
    endtask

    task automatic collect_results();
        int          i;
        int          cycles;
        logic        done;
        logic        held;
        logic [31:0] h_addr;
        logic [31:0] h_data;
        logic [4:0]  h_rd;
        logic        h_we;
        for (i = 0; i < n_entries; i++) begin
            if (!tbl_flush[i]) begin
                cycles = 0;
                done   = 1'b0;
                held   = 1'b0;
                while (!done) begin
                    @(negedge clk_i);
                    if (held) begin  // stalled beat must not move
                        assert (res_valid_o) else value_error("res_valid_o", 32'd1, 32'd0);
                        assert (res_addr_o == h_addr)
                            else value_error("res_addr_o while stalled", h_addr, res_addr_o);
                        assert (res_rd_o == h_rd)
                            else value_error("res_rd_o while stalled", h_rd, res_rd_o);
                        assert (res_we_o == h_we)
                            else value_error("res_we_o while stalled", h_we, res_we_o);
                        assert (res_data_o == h_data)
                            else value_error("res_data_o while stalled", h_data, res_data_o);
                    end
                    if (res_valid_o && res_ready_i) begin
                        assert (res_addr_o == word_addr(i))
                            else value_error("res_addr_o", word_addr(i), res_addr_o);
                        assert (res_we_o == exp_we[i])
                            else value_error("res_we_o", exp_we[i], res_we_o);
                        assert (res_rd_o == tbl_inst[i][11:7])
                            else value_error("res_rd_o", tbl_inst[i][11:7], res_rd_o);
                        assert (!exp_we[i] || res_data_o == exp_data[i])
                            else value_error("res_data_o", exp_data[i], res_data_o);
                        done = 1'b1;
                    end else if (res_valid_o) begin
                        held   = 1'b1;
                        h_addr = res_addr_o;
                        h_rd   = res_rd_o;
                        h_we   = res_we_o;
                        h_data = res_data_o;
                    end
                    @(posedge clk_i);
                    #2;
                    lfsr_state  = lfsr_step(lfsr_state);
                    res_ready_i = lfsr_state[0] & ~hold_ready;
                    cycles++;
                    if (!done && cycles > TIMEOUT) timeout_abort("a result beat");
                end
                retired_count++;
            end
        end
    endtask

    initial begin
        int r;
        clk_i         = 1'b0;
        rst_n_i       = 1'b0;
        flush_i       = 1'b0;
        in_valid_i    = 1'b0;
        in_inst_i     = '0;
        in_addr_i     = '0;
        res_ready_i   = 1'b0;
        lfsr_state    = 16'd89;
        hold_ready    = 1'b0;
        n_entries     = 0;
        sent_count    = 0;
        retired_count = 0;
        for (r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        build_table();
        repeat (3) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;
        @(negedge clk_i);
        assert (in_ready_o) else value_error("in_ready_o after reset", 32'd1, 32'd0);
        assert (!res_valid_o) else value_error("res_valid_o after reset", 32'd0, 32'd1);
        @(posedge clk_i);
        #2;
        flush_i = 1'b1;  // empty pipe, so only the flush can hold ready low
        @(negedge clk_i);
        assert (!in_ready_o) else value_error("in_ready_o during flush", 32'd0, 32'd1);
        @(posedge clk_i);
        #2;
        flush_i = 1'b0;
        fork
            drive_inputs();
            collect_results();
        join
        res_ready_i = 1'b1;
        for (r = 0; r < 5; r++) begin  // nothing may retire twice
            @(negedge clk_i);
            assert (!res_valid_o) else value_error("res_valid_o after last beat", 32'd0, 32'd1);
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tiny_pipe.f ====
tiny_pipe_pkg.sv
tiny_pipe_regfile.sv
tiny_pipe_decode.sv
tiny_pipe_id_ex.sv
tiny_pipe_execute.sv
tiny_pipe_result.sv
tiny_pipe_top.sv
tb_tiny_pipe.sv

// ==== tiny_pipe_decode.sv ====
// tiny_pipe decode stage
// splits the instruction, builds forwarded operands and picks the ALU op
`timescale 1ns/1ps
`default_nettype none

module tiny_pipe_decode #(
    parameter int NUM_REGS = 32
) (
    input  logic [tiny_pipe_pkg::INST_W-1:0]     inst_i,
    output logic [tiny_pipe_pkg::REG_ADDR_W-1:0] raddr1_o,
    output logic [tiny_pipe_pkg::REG_ADDR_W-1:0] raddr2_o,
    input  logic [tiny_pipe_pkg::XLEN-1:0]       rdata1_i,
    input  logic [tiny_pipe_pkg::XLEN-1:0]       rdata2_i,
    input  logic                                ex_fwd_we_i,
    input  logic [tiny_pipe_pkg::REG_ADDR_W-1:0] ex_fwd_addr_i,
    input  logic [tiny_pipe_pkg::XLEN-1:0]       ex_fwd_data_i,
    input  logic                                res_fwd_we_i,
    input  logic [tiny_pipe_pkg::REG_ADDR_W-1:0] res_fwd_addr_i,
    input  logic [tiny_pipe_pkg::XLEN-1:0]       res_fwd_data_i,
    output logic [tiny_pipe_pkg::XLEN-1:0]       op1_o,
    output logic [tiny_pipe_pkg::XLEN-1:0]       op2_o,
    output tiny_pipe_pkg::alu_op_e              alu_op_o,
    output logic                                reg_we_o,
    output logic [tiny_pipe_pkg::REG_ADDR_W-1:0] reg_waddr_o
);
    import tiny_pipe_pkg::*;

    opcode_e               opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       imm_i;
    logic [XLEN-1:0]       imm_u;
    logic                  legal;
    logic                  alt_ok;  // funct7 may select sub/sra

    // youngest producer wins, x0 is never forwarded
    function automatic logic [XLEN-1:0] fwd(input logic [REG_ADDR_W-1:0] addr,
                                            input logic [XLEN-1:0]       rf_data);
        if (addr == '0) return '0;
        if (ex_fwd_we_i && ex_fwd_addr_i == addr) return ex_fwd_data_i;
        if (res_fwd_we_i && res_fwd_addr_i == addr) return res_fwd_data_i;
        return rf_data;
    endfunction

    assign raddr1_o = inst_i[19:15];
    assign raddr2_o = inst_i[24:20];
    assign rd       = inst_i[11:7];
    assign funct3   = inst_i[14:12];
    assign funct7   = inst_i[31:25];
    assign imm_i    = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_u    = {inst_i[31:12], 12'b0};

    always_comb begin
        case (inst_i[6:0])
            OP:      opcode = OP;
            OP_IMM:  opcode = OP_IMM;
            LUI:     opcode = LUI;
            default: opcode = OTHER;
        endcase
    end

    // addi has no sub form, srai/sra and sub share funct7[5]
    assign alt_ok = (funct3 == F3_SR) || (funct3 == F3_ADD && opcode == OP);

    always_comb begin
        legal    = 1'b0;
        op1_o    = fwd(raddr1_o, rdata1_i);
        op2_o    = fwd(raddr2_o, rdata2_i);
        alu_op_o = ALU_ADD;
        case (opcode)
            OP, OP_IMM: begin
                if (opcode == OP_IMM) op2_o = imm_i;
                if (opcode == OP_IMM && funct3 != F3_SLL && funct3 != F3_SR) begin
                    legal = 1'b1;  // funct7 bits are immediate here
                end else begin
                    legal = (funct7 == F7_BASE) || (funct7 == F7_ALT && alt_ok);
                end
                case (funct3)
                    F3_ADD:  alu_op_o = (funct7[5] && opcode == OP) ? ALU_SUB : ALU_ADD;
                    F3_SLL:  alu_op_o = ALU_SLL;
                    F3_SLT:  alu_op_o = ALU_SLT;
                    F3_SLTU: alu_op_o = ALU_SLTU;
                    F3_XOR:  alu_op_o = ALU_XOR;
                    F3_SR:   alu_op_o = funct7[5] ? ALU_SRA : ALU_SRL;
                    F3_OR:   alu_op_o = ALU_OR;
                    default: alu_op_o = ALU_AND;
                endcase
            end
            LUI: begin
                legal    = 1'b1;
                op2_o    = imm_u;
                alu_op_o = ALU_PASS2;
            end
            default: ;  // retires as a no-write word
        endcase
    end

    assign reg_waddr_o = rd;
    assign reg_we_o    = legal && rd != '0 && rd < NUM_REGS;

endmodule

`default_nettype wire

// ==== tiny_pipe_execute.sv ====
// tiny_pipe execute stage
// combinational ALU for the decoded operation
`timescale 1ns/1ps
`default_nettype none

module tiny_pipe_execute (
    input  logic [tiny_pipe_pkg::XLEN-1:0] op1_i,
    input  logic [tiny_pipe_pkg::XLEN-1:0] op2_i,
    input  tiny_pipe_pkg::alu_op_e        alu_op_i,
    output logic [tiny_pipe_pkg::XLEN-1:0] result_o
);
    import tiny_pipe_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = op2_i[4:0];  // rv32 shift amount
    assign lt_signed   = $signed(op1_i) < $signed(op2_i);
    assign lt_unsigned = op1_i < op2_i;

    always_comb begin
        case (alu_op_i)
            ALU_ADD:   result_o = op1_i + op2_i;
            ALU_SUB:   result_o = op1_i - op2_i;
            ALU_AND:   result_o = op1_i & op2_i;
            ALU_OR:    result_o = op1_i | op2_i;
            ALU_XOR:   result_o = op1_i ^ op2_i;
            ALU_SLT:   result_o = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU:  result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_SLL:   result_o = op1_i << shamt;
            ALU_SRL:   result_o = op1_i >> shamt;
            ALU_SRA:   result_o = $unsigned($signed(op1_i) >>> shamt);  // sign fill
            ALU_PASS2: result_o = op2_i;
            default:   result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== tiny_pipe_id_ex.sv ====
// tiny_pipe decode-to-execute register
// enabled register bank with clear on flush and a valid bit
`timescale 1ns/1ps
`default_nettype none

module tiny_pipe_id_ex (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                flush_i,
    input  logic                                in_valid_i,
    input  logic                                advance_i,
    input  logic [tiny_pipe_pkg::INST_W-1:0]     inst_i,
    input  logic [tiny_pipe_pkg::XLEN-1:0]       inst_addr_i,
    input  logic [tiny_pipe_pkg::XLEN-1:0]       op1_i,
    input  logic [tiny_pipe_pkg::XLEN-1:0]       op2_i,
    input  tiny_pipe_pkg::alu_op_e              alu_op_i,
    input  logic                                reg_we_i,
    input  logic [tiny_pipe_pkg::REG_ADDR_W-1:0] reg_waddr_i,
    output logic [tiny_pipe_pkg::INST_W-1:0]     inst_o,
    output logic [tiny_pipe_pkg::XLEN-1:0]       inst_addr_o,
    output logic [tiny_pipe_pkg::XLEN-1:0]       op1_o,
    output logic [tiny_pipe_pkg::XLEN-1:0]       op2_o,
    output tiny_pipe_pkg::alu_op_e              alu_op_o,
    output logic                                reg_we_o,
    output logic [tiny_pipe_pkg::REG_ADDR_W-1:0] reg_waddr_o,
    output logic                                valid_o,
    output logic                                in_ready_o
);
    import tiny_pipe_pkg::*;

    logic load;   // slot free or draining this cycle
    logic clear;  // load a bubble instead of a word

    assign load       = ~valid_o | advance_i;
    assign clear      = flush_i | (load & ~in_valid_i);
    assign in_ready_o = load & ~flush_i;

    // reg_we_o stays low whenever valid_o is low
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || clear) begin
            inst_o      <= INST_NOP;
            inst_addr_o <= '0;
            op1_o       <= '0;
            op2_o       <= '0;
            alu_op_o    <= ALU_ADD;
            reg_we_o    <= 1'b0;
            reg_waddr_o <= '0;
            valid_o     <= 1'b0;
        end else if (load) begin
            inst_o      <= inst_i;
            inst_addr_o <= inst_addr_i;
            op1_o       <= op1_i;
            op2_o       <= op2_i;
            alu_op_o    <= alu_op_i;
            reg_we_o    <= reg_we_i;
            reg_waddr_o <= reg_waddr_i;
            valid_o     <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== tiny_pipe_pkg.sv ====
// tiny_pipe shared definitions
// widths, opcode and ALU encodings, funct fields and the NOP word
`default_nettype none

package tiny_pipe_pkg;

    localparam int XLEN       = 32;  // data and address width
    localparam int INST_W     = 32;  // instruction width
    localparam int REG_ADDR_W = 5;   // register index width

    // addi x0, x0, 0
    localparam logic [INST_W-1:0] INST_NOP = 32'h0000_0013;

    // major opcodes the core knows about, inst[6:0]
    typedef enum logic [6:0] {
        OP     = 7'b0110011,  // register-register
        OP_IMM = 7'b0010011,  // register-immediate
        LUI    = 7'b0110111,
        OTHER  = 7'b0000000   // anything else, retires without a write
    } opcode_e;

    // funct3 codes shared by OP and OP_IMM
    localparam logic [2:0] F3_ADD  = 3'b000;  // add / sub / addi
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;  // srl / sra
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub, sra, srai

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,    // signed compare
        ALU_SLTU,   // unsigned compare
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS2   // op2 straight through, used by lui
    } alu_op_e;

endpackage

`default_nettype wire

// ==== tiny_pipe_regfile.sv ====
// tiny_pipe register file
// two asynchronous read ports, one synchronous write port, x0 reads zero
`timescale 1ns/1ps
`default_nettype none

module tiny_pipe_regfile #(
    parameter int NUM_REGS = 32
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic [tiny_pipe_pkg::REG_ADDR_W-1:0] raddr1_i,
    input  logic [tiny_pipe_pkg::REG_ADDR_W-1:0] raddr2_i,
    output logic [tiny_pipe_pkg::XLEN-1:0]       rdata1_o,
    output logic [tiny_pipe_pkg::XLEN-1:0]       rdata2_o,
    input  logic                                we_i,
    input  logic [tiny_pipe_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [tiny_pipe_pkg::XLEN-1:0]       wdata_i
);
    import tiny_pipe_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0 && waddr_i < NUM_REGS) begin
            regs[waddr_i] <= wdata_i;  // x0 and out-of-range dropped
        end
    end

    assign rdata1_o = (raddr1_i != '0 && raddr1_i < NUM_REGS) ? regs[raddr1_i] : '0;
    assign rdata2_o = (raddr2_i != '0 && raddr2_i < NUM_REGS) ? regs[raddr2_i] : '0;

endmodule

`default_nettype wire

// ==== tiny_pipe_result.sv ====
// tiny_pipe result stage
// holds one retired instruction, drives the result port and write-back
`timescale 1ns/1ps
`default_nettype none

module tiny_pipe_result (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                ex_valid_i,
    input  logic [tiny_pipe_pkg::XLEN-1:0]       ex_addr_i,
    input  logic                                ex_we_i,
    input  logic [tiny_pipe_pkg::REG_ADDR_W-1:0] ex_rd_i,
    input  logic [tiny_pipe_pkg::XLEN-1:0]       ex_data_i,
    output logic                                advance_o,
    output logic                                res_valid_o,
    output logic [tiny_pipe_pkg::XLEN-1:0]       res_addr_o,
    output logic [tiny_pipe_pkg::REG_ADDR_W-1:0] res_rd_o,
    output logic                                res_we_o,
    output logic [tiny_pipe_pkg::XLEN-1:0]       res_data_o,
    input  logic                                res_ready_i,
    output logic                                rf_we_o,
    output logic [tiny_pipe_pkg::REG_ADDR_W-1:0] rf_waddr_o,
    output logic [tiny_pipe_pkg::XLEN-1:0]       rf_wdata_o
);

    assign advance_o = ~res_valid_o | res_ready_i;  // empty or being consumed

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            res_valid_o <= 1'b0;
            res_we_o    <= 1'b0;
        end else if (advance_o) begin
            res_valid_o <= ex_valid_i;
            res_we_o    <= ex_valid_i & ex_we_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (advance_o) begin
            res_addr_o <= ex_addr_i;
            res_rd_o   <= ex_rd_i;
            res_data_o <= ex_data_i;
        end
    end

    // commit on the consuming edge
    assign rf_we_o    = res_valid_o & res_we_o & res_ready_i;
    assign rf_waddr_o = res_rd_o;
    assign rf_wdata_o = res_data_o;

endmodule

`default_nettype wire

// ==== tiny_pipe_top.sv ====
// tiny_pipe top level
// decode, id/ex register, execute and result stage around the register file
`timescale 1ns/1ps
`default_nettype none

module tiny_pipe_top #(
    parameter int NUM_REGS = 32  // 16 for rv32e
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                flush_i,
    input  logic                                in_valid_i,
    input  logic [tiny_pipe_pkg::INST_W-1:0]     in_inst_i,
    input  logic [tiny_pipe_pkg::XLEN-1:0]       in_addr_i,
    output logic                                in_ready_o,
    output logic                                res_valid_o,
    output logic [tiny_pipe_pkg::XLEN-1:0]       res_addr_o,
    output logic [tiny_pipe_pkg::REG_ADDR_W-1:0] res_rd_o,
    output logic                                res_we_o,
    output logic [tiny_pipe_pkg::XLEN-1:0]       res_data_o,
    input  logic                                res_ready_i
);
    import tiny_pipe_pkg::*;

    logic [REG_ADDR_W-1:0] rf_raddr1, rf_raddr2, rf_waddr;
    logic [XLEN-1:0]       rf_rdata1, rf_rdata2, rf_wdata;
    logic                  rf_we;

    logic [XLEN-1:0]       id_op1, id_op2;
    alu_op_e               id_alu_op;
    logic                  id_reg_we;
    logic [REG_ADDR_W-1:0] id_reg_waddr;

    logic [XLEN-1:0]       ex_addr, ex_op1, ex_op2, ex_result;
    alu_op_e               ex_alu_op;
    logic                  ex_reg_we, ex_valid;
    logic [REG_ADDR_W-1:0] ex_reg_waddr;
    logic                  advance;

    tiny_pipe_regfile #(.NUM_REGS(NUM_REGS)) i_regfile (
        .clk_i, .rst_n_i,
        .raddr1_i(rf_raddr1), .raddr2_i(rf_raddr2),
        .rdata1_o(rf_rdata1), .rdata2_o(rf_rdata2),
        .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata)
    );

    tiny_pipe_decode #(.NUM_REGS(NUM_REGS)) i_decode (
        .inst_i(in_inst_i),
        .raddr1_o(rf_raddr1), .raddr2_o(rf_raddr2),
        .rdata1_i(rf_rdata1), .rdata2_i(rf_rdata2),
        .ex_fwd_we_i(ex_reg_we), .ex_fwd_addr_i(ex_reg_waddr), .ex_fwd_data_i(ex_result),
        .res_fwd_we_i(res_we_o), .res_fwd_addr_i(res_rd_o), .res_fwd_data_i(res_data_o),
        .op1_o(id_op1), .op2_o(id_op2), .alu_op_o(id_alu_op),
        .reg_we_o(id_reg_we), .reg_waddr_o(id_reg_waddr)
    );

    tiny_pipe_id_ex i_id_ex (
        .clk_i, .rst_n_i, .flush_i, .in_valid_i,
        .advance_i(advance),
        .inst_i(in_inst_i), .inst_addr_i(in_addr_i),
        .op1_i(id_op1), .op2_i(id_op2), .alu_op_i(id_alu_op),
        .reg_we_i(id_reg_we), .reg_waddr_i(id_reg_waddr),
        .inst_o(),  // trace only
        .inst_addr_o(ex_addr),
        .op1_o(ex_op1), .op2_o(ex_op2), .alu_op_o(ex_alu_op),
        .reg_we_o(ex_reg_we), .reg_waddr_o(ex_reg_waddr),
        .valid_o(ex_valid), .in_ready_o
    );

    tiny_pipe_execute i_execute (
        .op1_i(ex_op1), .op2_i(ex_op2), .alu_op_i(ex_alu_op), .result_o(ex_result)
    );

    tiny_pipe_result i_result (
        .clk_i, .rst_n_i,
        .ex_valid_i(ex_valid), .ex_addr_i(ex_addr), .ex_we_i(ex_reg_we),
        .ex_rd_i(ex_reg_waddr), .ex_data_i(ex_result),
        .advance_o(advance),
        .res_valid_o, .res_addr_o, .res_rd_o, .res_we_o, .res_data_o, .res_ready_i,
        .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata)
    );

endmodule

`default_nettype wire
